/* lb_addr_pkg.sv */
`default_nettype none

package lb_addr_pkg;

    // frame geometry
    localparam int IMG_W       = 4;
    localparam int ROW_COUNT   = 3;
    localparam int WORD_STRIDE = 16;

    localparam int URAM_A_W = 23;
    localparam int BRAM_A_W = 14;

    typedef logic [URAM_A_W-1:0] uram_addr_t;
    typedef logic [BRAM_A_W-1:0] bram_addr_t;

    // row buffer addresses wrap to zero after this one
    localparam bram_addr_t ROW_LAST_ADDR = bram_addr_t'(WORD_STRIDE * (IMG_W - 1));

    // pipeline latencies in clock cycles
    localparam int B1_WR_DELAY   = 5;
    localparam int ROW1_RD_DELAY = 5;
    localparam int ROW2_RD_DELAY = 8;
    localparam int FWD_DELAY     = 2;

    function automatic bram_addr_t row_addr_step(input bram_addr_t addr);
        if (addr == ROW_LAST_ADDR) begin
            return '0;
        end
        return addr + bram_addr_t'(WORD_STRIDE);
    endfunction

endpackage

`default_nettype wire

/* lb_state_pkg.sv */
`default_nettype none

package lb_state_pkg;

    // URAM fill sequencer
    typedef enum logic [2:0] {
        FILL_RESET = 3'd0,
        FILL_INIT  = 3'd1,
        FILL_ROW0  = 3'd2,
        FILL_ROW1  = 3'd3,
        FILL_ROW2  = 3'd4,
        FILL_DONE  = 3'd5
    } fill_state_t;

    // initial read of one row buffer
    typedef enum logic [1:0] {
        ROW_RESET = 2'd0,
        ROW_WAIT  = 2'd1,
        ROW_READ  = 2'd2,
        ROW_DONE  = 2'd3
    } row_state_t;

endpackage

`default_nettype wire

/* uram_fill_ctrl.sv */
`default_nettype none
`timescale 1ns/1ps

module uram_fill_ctrl (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    stream_rd,
    output lb_addr_pkg::uram_addr_t uram_rd_addr,
    output lb_addr_pkg::bram_addr_t b1_wr_addr,
    output logic                    b1_wr_en,
    output logic                    row1_fill_rd,
    output logic                    row2_fill_rd
);
    import lb_addr_pkg::*;
    import lb_state_pkg::*;

    fill_state_t state;
    fill_state_t next_state;
    logic        fill_rd;
    logic        uram_rd_en;
    bram_addr_t  b1_addr_cnt;
    bram_addr_t  b1_addr_pipe [B1_WR_DELAY];
    logic        b1_en_pipe   [B1_WR_DELAY];

    // URAM address of the last word of a row
    function automatic uram_addr_t row_end(input int unsigned row);
        return uram_addr_t'(WORD_STRIDE * ((row + 1) * IMG_W - 1));
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= FILL_RESET;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            FILL_RESET: next_state = FILL_INIT;
            FILL_INIT:  next_state = FILL_ROW0;
            FILL_ROW0: begin
                if (uram_rd_addr == row_end(0)) begin
                    next_state = FILL_ROW1;
                end
            end
            FILL_ROW1: begin
                if (uram_rd_addr == row_end(1)) begin
                    next_state = FILL_ROW2;
                end
            end
            FILL_ROW2: begin
                if (uram_rd_addr == row_end(ROW_COUNT - 1)) begin
                    next_state = FILL_DONE;
                end
            end
            FILL_DONE:  next_state = FILL_DONE;
            default:    next_state = FILL_RESET;
        endcase
    end

    // flags follow the next state so they line up with the address
    always_ff @(posedge clk) begin
        if (rst) begin
            fill_rd      <= 1'b0;
            row1_fill_rd <= 1'b0;
            row2_fill_rd <= 1'b0;
        end else begin
            fill_rd      <= next_state inside {FILL_ROW0, FILL_ROW1, FILL_ROW2};
            row1_fill_rd <= next_state inside {FILL_ROW0, FILL_ROW1};
            row2_fill_rd <= (next_state == FILL_ROW0);
        end
    end

    assign uram_rd_en = fill_rd || stream_rd;

    always_ff @(posedge clk) begin
        if (rst || state == FILL_INIT) begin
            uram_rd_addr <= '0;
        end else if (uram_rd_en) begin
            uram_rd_addr <= uram_rd_addr + uram_addr_t'(WORD_STRIDE);
        end
    end

    // BRAM1 write address, one row long
    always_ff @(posedge clk) begin
        if (rst) begin
            b1_addr_cnt <= '0;
        end else if (uram_rd_en) begin
            b1_addr_cnt <= row_addr_step(b1_addr_cnt);
        end
    end

    // match the URAM read latency plus data register
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < B1_WR_DELAY; i++) begin
                b1_addr_pipe[i] <= '0;
                b1_en_pipe[i]   <= 1'b0;
            end
        end else begin
            b1_addr_pipe[0] <= b1_addr_cnt;
            b1_en_pipe[0]   <= uram_rd_en;
            for (int i = 1; i < B1_WR_DELAY; i++) begin
                b1_addr_pipe[i] <= b1_addr_pipe[i-1];
                b1_en_pipe[i]   <= b1_en_pipe[i-1];
            end
        end
    end

    assign b1_wr_addr = b1_addr_pipe[B1_WR_DELAY-1];
    assign b1_wr_en   = b1_en_pipe[B1_WR_DELAY-1];

endmodule

`default_nettype wire

/* row_read_ctrl.sv */
`default_nettype none
`timescale 1ns/1ps

module row_read_ctrl #(
    parameter int FILL_DELAY = lb_addr_pkg::ROW1_RD_DELAY
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    fill_rd,
    input  logic                    shift_rd,
    output lb_addr_pkg::bram_addr_t rd_addr,
    output lb_addr_pkg::bram_addr_t next_wr_addr,
    output logic                    next_wr_en,
    output logic                    done
);
    import lb_addr_pkg::*;
    import lb_state_pkg::*;

    row_state_t state;
    row_state_t next_state;
    logic       fill_pipe [FILL_DELAY];
    logic       fill_dly;
    logic       rd_en;
    bram_addr_t fwd_addr_pipe [FWD_DELAY];
    logic       fwd_en_pipe   [FWD_DELAY];

    // several fill reads are in flight at once
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < FILL_DELAY; i++) begin
                fill_pipe[i] <= 1'b0;
            end
        end else begin
            fill_pipe[0] <= fill_rd;
            for (int i = 1; i < FILL_DELAY; i++) begin
                fill_pipe[i] <= fill_pipe[i-1];
            end
        end
    end

    assign fill_dly = fill_pipe[FILL_DELAY-1];
    assign rd_en    = fill_dly || shift_rd;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ROW_RESET;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            ROW_RESET: next_state = ROW_WAIT;
            ROW_WAIT: begin
                if (fill_dly) begin
                    next_state = ROW_READ;
                end
            end
            ROW_READ: begin
                if (!fill_dly) begin
                    next_state = ROW_DONE;
                end
            end
            default:   next_state = ROW_DONE;
        endcase
    end

    assign done = (state == ROW_DONE);

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_addr <= '0;
        end else if (rd_en) begin
            rd_addr <= row_addr_step(rd_addr);
        end
    end

    // read data reaches the next buffer after FWD_DELAY cycles
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < FWD_DELAY; i++) begin
                fwd_addr_pipe[i] <= '0;
                fwd_en_pipe[i]   <= 1'b0;
            end
        end else begin
            fwd_addr_pipe[0] <= rd_addr;
            fwd_en_pipe[0]   <= rd_en;
            for (int i = 1; i < FWD_DELAY; i++) begin
                fwd_addr_pipe[i] <= fwd_addr_pipe[i-1];
                fwd_en_pipe[i]   <= fwd_en_pipe[i-1];
            end
        end
    end

    assign next_wr_addr = fwd_addr_pipe[FWD_DELAY-1];
    assign next_wr_en   = fwd_en_pipe[FWD_DELAY-1];

endmodule

`default_nettype wire

/* steady_read_ctrl.sv */
`default_nettype none
`timescale 1ns/1ps

module steady_read_ctrl (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    stream_rd,
    input  logic                    row1_done,
    input  logic                    row2_done,
    output logic                    shift_rd,
    output lb_addr_pkg::bram_addr_t b3_rd_addr,
    output logic                    init_done
);
    import lb_addr_pkg::*;

    // one register on the request path
    always_ff @(posedge clk) begin
        if (rst) begin
            shift_rd <= 1'b0;
        end else begin
            shift_rd <= stream_rd;
        end
    end

    // BRAM3 is only read in steady state
    always_ff @(posedge clk) begin
        if (rst) begin
            b3_rd_addr <= '0;
        end else if (shift_rd) begin
            b3_rd_addr <= row_addr_step(b3_rd_addr);
        end
    end

    // both controllers hold ROW_DONE until reset
    assign init_done = row1_done && row2_done;

endmodule

`default_nettype wire

/* line_buffer_addr_gen.sv */
`default_nettype none
`timescale 1ns/1ps

module line_buffer_addr_gen (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    stream_rd,
    output lb_addr_pkg::uram_addr_t uram_rd_addr,
    output lb_addr_pkg::bram_addr_t b1_wr_addr,
    output logic                    b1_wr_en,
    output lb_addr_pkg::bram_addr_t b2_wr_addr,
    output logic                    b2_wr_en,
    output lb_addr_pkg::bram_addr_t b3_wr_addr,
    output logic                    b3_wr_en,
    output lb_addr_pkg::bram_addr_t b1_rd_addr,
    output lb_addr_pkg::bram_addr_t b2_rd_addr,
    output lb_addr_pkg::bram_addr_t b3_rd_addr,
    output logic                    init_done
);
    import lb_addr_pkg::*;

    logic row1_fill_rd;
    logic row2_fill_rd;
    logic shift_rd;
    logic row1_done;
    logic row2_done;

    uram_fill_ctrl u_fill (
        .clk          (clk),
        .rst          (rst),
        .stream_rd    (stream_rd),
        .uram_rd_addr (uram_rd_addr),
        .b1_wr_addr   (b1_wr_addr),
        .b1_wr_en     (b1_wr_en),
        .row1_fill_rd (row1_fill_rd),
        .row2_fill_rd (row2_fill_rd)
    );

    // BRAM1 read, BRAM2 write
    row_read_ctrl #(
        .FILL_DELAY (ROW1_RD_DELAY)
    ) u_row1 (
        .clk          (clk),
        .rst          (rst),
        .fill_rd      (row1_fill_rd),
        .shift_rd     (shift_rd),
        .rd_addr      (b1_rd_addr),
        .next_wr_addr (b2_wr_addr),
        .next_wr_en   (b2_wr_en),
        .done         (row1_done)
    );

    // BRAM2 read, BRAM3 write
    row_read_ctrl #(
        .FILL_DELAY (ROW2_RD_DELAY)
    ) u_row2 (
        .clk          (clk),
        .rst          (rst),
        .fill_rd      (row2_fill_rd),
        .shift_rd     (shift_rd),
        .rd_addr      (b2_rd_addr),
        .next_wr_addr (b3_wr_addr),
        .next_wr_en   (b3_wr_en),
        .done         (row2_done)
    );

    steady_read_ctrl u_steady (
        .clk        (clk),
        .rst        (rst),
        .stream_rd  (stream_rd),
        .row1_done  (row1_done),
        .row2_done  (row2_done),
        .shift_rd   (shift_rd),
        .b3_rd_addr (b3_rd_addr),
        .init_done  (init_done)
    );

endmodule

`default_nettype wire

/* line_buffer_addr_gen_checker.sv */
`default_nettype none
`timescale 1ns/1ps

module line_buffer_addr_gen_checker (
    input logic                    clk,
    input logic                    rst,
    input lb_addr_pkg::bram_addr_t b1_wr_addr,
    input logic                    b1_wr_en,
    input lb_addr_pkg::bram_addr_t b2_wr_addr,
    input logic                    b2_wr_en,
    input lb_addr_pkg::bram_addr_t b3_wr_addr,
    input logic                    b3_wr_en,
    input logic                    init_done
);
    import lb_addr_pkg::*;

    int unsigned fail_count = 0;

    // one reset edge first so the pipelines hold their reset values
    no_write_in_reset: assert property (@(posedge clk)
        rst && $past(rst) |-> !(b1_wr_en || b2_wr_en || b3_wr_en))
        else begin
            $error("write enable high during reset");
            fail_count++;
        end

    init_done_holds: assert property (@(posedge clk) disable iff (rst)
        !$past(rst) |-> !$fell(init_done))
        else begin
            $error("init_done fell without reset");
            fail_count++;
        end

    b1_addr_in_row: assert property (@(posedge clk) disable iff (rst)
        b1_wr_en |-> b1_wr_addr <= ROW_LAST_ADDR)
        else begin
            $error("BRAM1 write address beyond the row");
            fail_count++;
        end

    b2_addr_in_row: assert property (@(posedge clk) disable iff (rst)
        b2_wr_en |-> b2_wr_addr <= ROW_LAST_ADDR)
        else begin
            $error("BRAM2 write address beyond the row");
            fail_count++;
        end

    b3_addr_in_row: assert property (@(posedge clk) disable iff (rst)
        b3_wr_en |-> b3_wr_addr <= ROW_LAST_ADDR)
        else begin
            $error("BRAM3 write address beyond the row");
            fail_count++;
        end

endmodule

bind line_buffer_addr_gen line_buffer_addr_gen_checker u_checker (
    .clk        (clk),
    .rst        (rst),
    .b1_wr_addr (b1_wr_addr),
    .b1_wr_en   (b1_wr_en),
    .b2_wr_addr (b2_wr_addr),
    .b2_wr_en   (b2_wr_en),
    .b3_wr_addr (b3_wr_addr),
    .b3_wr_en   (b3_wr_en),
    .init_done  (init_done)
);

`default_nettype wire

/* tb_line_buffer_addr_gen.sv */
`default_nettype none
`timescale 1ns/1ps

module tb_line_buffer_addr_gen;
    import lb_addr_pkg::*;

    localparam int RESET_CYCLES = 16;
    localparam int FILL_START   = 2;
    localparam int FILL_READS   = ROW_COUNT * IMG_W;
    localparam int FILL_CYCLES  = 40;
    localparam int MIN_STROBES  = 12;
    localparam int MAX_STROBES  = 20;
    localparam int MAX_GAP      = 3;
    localparam int DRAIN_CYCLES = B1_WR_DELAY + FWD_DELAY + 2;
    localparam int RUN_CYCLES   = RESET_CYCLES + FILL_CYCLES + MAX_STROBES * (MAX_GAP + 1);
    localparam int MAX_CYCLES   = 2 * RUN_CYCLES + 128;

    logic       clk;
    logic       rst;
    logic       stream_rd;
    uram_addr_t uram_rd_addr;
    bram_addr_t b1_wr_addr;
    logic       b1_wr_en;
    bram_addr_t b2_wr_addr;
    logic       b2_wr_en;
    bram_addr_t b3_wr_addr;
    logic       b3_wr_en;
    bram_addr_t b1_rd_addr;
    bram_addr_t b2_rd_addr;
    bram_addr_t b3_rd_addr;
    logic       init_done;

    logic [15:0] lfsr;
    int          cyc;
    int          cycle_count;
    int          mismatch_count;
    int          b1_writes;
    int          b2_writes;
    int          b3_writes;
    int          strobes;
    int          gap;
    logic        streaming;
    logic        init_seen;
    logic        rd_now;
    logic        fwd_exp;
    uram_addr_t  exp_uram;
    bram_addr_t  exp_b1;
    bram_addr_t  exp_b2;
    bram_addr_t  exp_b3;
    logic        rd_hist     [MAX_CYCLES];
    logic        stream_hist [MAX_CYCLES];

    line_buffer_addr_gen u_line_buffer_addr_gen (
        .clk          (clk),
        .rst          (rst),
        .stream_rd    (stream_rd),
        .uram_rd_addr (uram_rd_addr),
        .b1_wr_addr   (b1_wr_addr),
        .b1_wr_en     (b1_wr_en),
        .b2_wr_addr   (b2_wr_addr),
        .b2_wr_en     (b2_wr_en),
        .b3_wr_addr   (b3_wr_addr),
        .b3_wr_en     (b3_wr_en),
        .b1_rd_addr   (b1_rd_addr),
        .b2_rd_addr   (b2_rd_addr),
        .b3_rd_addr   (b3_rd_addr),
        .init_done    (init_done)
    );

    // word index plus one, modulo the row length
    function automatic bram_addr_t next_row_addr(input bram_addr_t addr);
        return bram_addr_t'(((int'(addr) / WORD_STRIDE + 1) % IMG_W) * WORD_STRIDE);
    endfunction

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output int value);
        value = 0;
        for (int i = 0; i < n; i++) begin
            value = (value << 1) | int'(lfsr[0]);
            lfsr  = lfsr_next(lfsr);
        end
    endtask

    task automatic check_uram_addr(input uram_addr_t got, input uram_addr_t exp,
                                   input string what);
        if (got !== exp) begin
            mismatch_count++;
            $display("Mismatch at %0t: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_bram_addr(input bram_addr_t got, input bram_addr_t exp,
                                   input string what);
        if (got !== exp) begin
            mismatch_count++;
            $display("Mismatch at %0t: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            mismatch_count++;
            $display("Mismatch at %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_count(input int got, input int exp, input string what);
        if (got != exp) begin
            mismatch_count++;
            $display("Mismatch at %0t: %s count is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic print_counts();
        $display("error counts: %0d mismatches, %0d assertion failures",
                 mismatch_count, u_line_buffer_addr_gen.u_checker.fail_count);
    endtask

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // compare process, samples before the DUT registers update
    always @(posedge clk) begin
        if (rst) begin
            cyc        = 0;
            exp_uram   = '0;
            exp_b1     = '0;
            exp_b2     = '0;
            exp_b3     = '0;
            b1_writes  = 0;
            b2_writes  = 0;
            b3_writes  = 0;
            init_seen  = 1'b0;
        end else begin
            if (cyc == 0) begin
                check_flag(b2_wr_en, 1'b0, "b2_wr_en after reset");
                check_flag(b3_wr_en, 1'b0, "b3_wr_en after reset");
                check_flag(init_done, 1'b0, "init_done after reset");
                check_bram_addr(b1_rd_addr, '0, "b1_rd_addr after reset");
                check_bram_addr(b2_rd_addr, '0, "b2_rd_addr after reset");
                check_bram_addr(b3_rd_addr, '0, "b3_rd_addr after reset");
            end
            rd_now = (cyc >= FILL_START && cyc < FILL_START + FILL_READS) || stream_rd;
            rd_hist[cyc]     = rd_now;
            stream_hist[cyc] = stream_rd;
            check_uram_addr(uram_rd_addr, exp_uram, "uram_rd_addr");
            if (rd_now) begin
                exp_uram = exp_uram + uram_addr_t'(WORD_STRIDE);
            end
            check_flag(b1_wr_en, (cyc >= B1_WR_DELAY) ? rd_hist[cyc-B1_WR_DELAY] : 1'b0,
                       "b1_wr_en");
            // shift_rd is one register behind stream_rd
            if (streaming) begin
                fwd_exp = (cyc >= 1 + FWD_DELAY) ? stream_hist[cyc-1-FWD_DELAY] : 1'b0;
                check_flag(b2_wr_en, fwd_exp, "b2_wr_en");
                check_flag(b3_wr_en, fwd_exp, "b3_wr_en");
            end
            if (b1_wr_en) begin
                check_bram_addr(b1_wr_addr, exp_b1, "b1_wr_addr");
                exp_b1 = next_row_addr(exp_b1);
                b1_writes++;
            end
            if (b2_wr_en) begin
                check_bram_addr(b2_wr_addr, exp_b2, "b2_wr_addr");
                exp_b2 = next_row_addr(exp_b2);
                b2_writes++;
            end
            if (b3_wr_en) begin
                check_bram_addr(b3_wr_addr, exp_b3, "b3_wr_addr");
                exp_b3 = next_row_addr(exp_b3);
                b3_writes++;
            end
            if (init_seen) begin
                check_flag(init_done, 1'b1, "init_done");
            end
            if (init_done) begin
                init_seen = 1'b1;
            end
            if (cyc < MAX_CYCLES - 1) begin
                cyc++;
            end
        end
    end

    initial begin
        rst            = 1'b1;
        stream_rd      = 1'b0;
        streaming      = 1'b0;
        mismatch_count = 0;
        lfsr           = 16'd8;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        while (!init_done) @(negedge clk);
        // let the fill writes drain out of the pipelines
        repeat (DRAIN_CYCLES) @(negedge clk);
        check_count(b1_writes, FILL_READS, "BRAM1 fill write");
        check_count(b2_writes, 2 * IMG_W, "BRAM2 fill write");
        check_count(b3_writes, IMG_W, "BRAM3 fill write");
        check_uram_addr(uram_rd_addr, uram_addr_t'(FILL_READS * WORD_STRIDE), "uram_rd_addr held");
        take_bits(4, strobes);
        strobes   = MIN_STROBES + strobes % (MAX_STROBES - MIN_STROBES + 1);
        streaming = 1'b1;
        for (int i = 0; i < strobes; i++) begin
            stream_rd = 1'b1;
            @(negedge clk);
            stream_rd = 1'b0;
            take_bits(2, gap);
            repeat (gap) @(negedge clk);
        end
        repeat (DRAIN_CYCLES) @(negedge clk);
        check_uram_addr(uram_rd_addr, uram_addr_t'((FILL_READS + strobes) * WORD_STRIDE),
                        "uram_rd_addr after stream");
        check_count(b1_writes, FILL_READS + strobes, "BRAM1 write");
        check_count(b2_writes, 2 * IMG_W + strobes, "BRAM2 write");
        check_count(b3_writes, IMG_W + strobes, "BRAM3 write");
        check_bram_addr(b1_rd_addr, bram_addr_t'((strobes % IMG_W) * WORD_STRIDE), "b1_rd_addr");
        check_bram_addr(b2_rd_addr, bram_addr_t'((strobes % IMG_W) * WORD_STRIDE), "b2_rd_addr");
        check_bram_addr(b3_rd_addr, bram_addr_t'((strobes % IMG_W) * WORD_STRIDE), "b3_rd_addr");
        print_counts();
        if (mismatch_count == 0 && u_line_buffer_addr_gen.u_checker.fail_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < MAX_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("run timed out after %0d cycles without finishing the test", cycle_count);
        print_counts();
        $display("Checks failed");
        $finish;
    end

endmodule

`default_nettype wire

/* project.f */
lb_addr_pkg.sv
lb_state_pkg.sv
uram_fill_ctrl.sv
row_read_ctrl.sv
steady_read_ctrl.sv
line_buffer_addr_gen.sv
line_buffer_addr_gen_checker.sv
tb_line_buffer_addr_gen.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f project.f --top-module tb_line_buffer_addr_gen \
    -o sim_tb \
    && ./obj_dir/sim_tb +verilator+error+limit+100 2>&1 | tee /dev/stderr \
    | grep -q "All checks passed" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
